/* csr_config.svh */
/*
 * configuration macros for the CSR execute unit
 * data width, rename bits and machine CSR addresses
 * read-only information values and the writable register reset value
 */
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// data path width of the RV64 core
`define CSR_XLEN 64
// rename bits appended above the 5-bit architectural register index
`define CSR_RNBIT 2
// all decoded CSRs, and the writable ones that lead the select vector
`define CSR_NUM 12
`define CSR_NUM_WR 7

// machine trap setup and trap handling addresses
`define CSR_ADDR_MSTATUS 12'h300
`define CSR_ADDR_MISA 12'h301
`define CSR_ADDR_MIE 12'h304
`define CSR_ADDR_MTVEC 12'h305
`define CSR_ADDR_MEPC 12'h341
`define CSR_ADDR_MCAUSE 12'h342
`define CSR_ADDR_MTVAL 12'h343
`define CSR_ADDR_MIP 12'h344

// machine information addresses, all read only
`define CSR_ADDR_MVENDORID 12'hF11
`define CSR_ADDR_MARCHID 12'hF12
`define CSR_ADDR_MIMPID 12'hF13
`define CSR_ADDR_MHARTID 12'hF14

// misa reports MXL = 2 for RV64 and only the I extension (bit 8)
`define CSR_MISA_VAL 64'h8000_0000_0000_0100
`define CSR_HART_ID 64'h0
// mvendorid is a 32-bit register even on RV64
`define CSR_MVENDORID_VAL 32'h0
`define CSR_MARCHID_VAL 64'h0
`define CSR_MIMPID_VAL 64'h0
// every writable CSR leaves reset at this value
`define CSR_RST_VAL 64'h0

`endif

/* csr_ctrl.sv */
/*
 * control of the CSR execute unit
 * address decode into a one-hot select, function vector, read and write
 * suppression, write enable gating and the registered writeback outputs
 */
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_ctrl
	import csr_pkg::*;
(
	input logic CLK,
	input logic arst_n,

	// operation from issue, all fields qualified by csr_valid
	input logic csr_valid,
	input logic csr_rw,
	input logic csr_rs,
	input logic csr_rc,
	input csr_rd_t csr_rd,
	input csr_data_t csr_op,
	input csr_addr_t csr_addr,

	// old value of the addressed CSR, straight from the read mux
	input csr_data_t rdata,

	output csr_sel_t sel,
	output csr_wr_t wr_en,
	output csr_fn_t fn,
	output csr_data_t op,

	// writeback port, one cycle after csr_valid
	output logic wb_valid,
	output csr_data_t wb_res,
	output csr_rd_t wb_rd
);

	logic dont_read;
	logic dont_write;
	logic wr_ok;
	csr_data_t res_d;

	// address decode, order follows csr_sel_t
	// an address outside this list leaves every bit low and reads zero
	assign sel[0] = (csr_addr == `CSR_ADDR_MSTATUS);
	assign sel[1] = (csr_addr == `CSR_ADDR_MIE);
	assign sel[2] = (csr_addr == `CSR_ADDR_MTVEC);
	assign sel[3] = (csr_addr == `CSR_ADDR_MEPC);
	assign sel[4] = (csr_addr == `CSR_ADDR_MCAUSE);
	assign sel[5] = (csr_addr == `CSR_ADDR_MTVAL);
	assign sel[6] = (csr_addr == `CSR_ADDR_MIP);
	assign sel[7] = (csr_addr == `CSR_ADDR_MISA);
	assign sel[8] = (csr_addr == `CSR_ADDR_MVENDORID);
	assign sel[9] = (csr_addr == `CSR_ADDR_MARCHID);
	assign sel[10] = (csr_addr == `CSR_ADDR_MIMPID);
	assign sel[11] = (csr_addr == `CSR_ADDR_MHARTID);

	// the strobes are one-hot already, they are just packed for the file
	assign fn = {csr_rc, csr_rs, csr_rw};
	assign op = csr_op;

	// csrrw into x0 has no read side effect, so the result is forced to zero
	assign dont_read = csr_rw & (csr_rd == '0);

	// csrrs and csrrc with a zero operand must not write at all
	assign dont_write = (csr_rs | csr_rc) & (csr_op == '0);

	// a write needs a live operation with some function strobe set
	assign wr_ok = csr_valid & (csr_rw | csr_rs | csr_rc) & ~dont_write;

	// read-only and unknown addresses have no bit in the low slice,
	// so writes to them fall away here
	assign wr_en = sel[`CSR_NUM_WR-1:0] & {`CSR_NUM_WR{wr_ok}};

	// the read returns the value held before this operation's own write
	assign res_d = dont_read ? '0 : rdata;

	// writeback registers
	// valid follows the strobe every cycle, the payload only loads with it
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid <= 1'b0;
			wb_res <= '0;
			wb_rd <= '0;
		end else begin
			wb_valid <= csr_valid;
			if (csr_valid) begin
				wb_res <= res_d;
				wb_rd <= csr_rd;
			end
		end
	end

endmodule

/* csr_exe_top.f */
+incdir+.
csr_pkg.sv
csr_ctrl.sv
csr_file.sv
csr_read_mux.sv
csr_exe_top.sv
tb_csr_exe_top.sv

/* csr_exe_top.sv */
/*
 * top level of the machine mode CSR execute unit
 * control with decode and writeback, the CSR storage and the read mux
 */
`timescale 1ns/1ps

module csr_exe_top
	import csr_pkg::*;
(
	input logic CLK,
	input logic arst_n,

	// operation strobe and fields
	input logic csr_valid,
	input logic csr_rw,
	input logic csr_rs,
	input logic csr_rc,
	input csr_rd_t csr_rd,
	input csr_data_t csr_op,
	input csr_addr_t csr_addr,

	// result, one cycle later
	output logic wb_valid,
	output csr_data_t wb_res,
	output csr_rd_t wb_rd
);

	csr_sel_t sel;
	csr_wr_t wr_en;
	csr_fn_t fn;
	csr_data_t op;
	csr_data_t rdata;

	// register values between the storage and the read mux
	csr_data_t mstatus;
	csr_data_t mie;
	csr_data_t mtvec;
	csr_data_t mepc;
	csr_data_t mcause;
	csr_data_t mtval;
	csr_data_t mip;

	csr_ctrl u_ctrl (
		.CLK(CLK),
		.arst_n(arst_n),
		.csr_valid(csr_valid),
		.csr_rw(csr_rw),
		.csr_rs(csr_rs),
		.csr_rc(csr_rc),
		.csr_rd(csr_rd),
		.csr_op(csr_op),
		.csr_addr(csr_addr),
		.rdata(rdata),
		.sel(sel),
		.wr_en(wr_en),
		.fn(fn),
		.op(op),
		.wb_valid(wb_valid),
		.wb_res(wb_res),
		.wb_rd(wb_rd)
	);

	// the merge reads the same rdata the control latches as the result
	csr_file u_file (
		.CLK(CLK),
		.arst_n(arst_n),
		.wr_en(wr_en),
		.fn(fn),
		.op(op),
		.rdata(rdata),
		.mstatus(mstatus),
		.mie(mie),
		.mtvec(mtvec),
		.mepc(mepc),
		.mcause(mcause),
		.mtval(mtval),
		.mip(mip)
	);

	csr_read_mux u_read_mux (
		.sel(sel),
		.mstatus(mstatus),
		.mie(mie),
		.mtvec(mtvec),
		.mepc(mepc),
		.mcause(mcause),
		.mtval(mtval),
		.mip(mip),
		.rdata(rdata)
	);

endmodule

/* csr_file.sv */
/*
 * writable machine CSR storage
 * write, set and clear merge against the current value, and the seven
 * registers mstatus, mie, mtvec, mepc, mcause, mtval and mip
 */
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_file
	import csr_pkg::*;
(
	input logic CLK,
	input logic arst_n,

	// at most one bit set, already gated by valid and the no-write rule
	input csr_wr_t wr_en,
	input csr_fn_t fn,
	input csr_data_t op,

	// current value of the selected CSR from the read mux
	input csr_data_t rdata,

	output csr_data_t mstatus,
	output csr_data_t mie,
	output csr_data_t mtvec,
	output csr_data_t mepc,
	output csr_data_t mcause,
	output csr_data_t mtval,
	output csr_data_t mip
);

	csr_data_t wdata;

	// register array indexed like csr_wr_t
	// 0 mstatus, 1 mie, 2 mtvec, 3 mepc, 4 mcause, 5 mtval, 6 mip
	csr_data_t csr_q [`CSR_NUM_WR];

	// merge of the old value with the operand
	// write takes the operand as is
	// set ORs the operand in, clear masks the operand bits out
	// only one function strobe is high, so the terms never overlap
	always_comb begin
		wdata = ({`CSR_XLEN{fn[0]}} & op)
			| ({`CSR_XLEN{fn[1]}} & (rdata | op))
			| ({`CSR_XLEN{fn[2]}} & (rdata & ~op));
	end

	// all registers are fully writable here
	// no WARL field legalisation is done, that comes with trap support
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `CSR_NUM_WR; i++) begin
				csr_q[i] <= `CSR_RST_VAL;
			end
		end else begin
			for (int i = 0; i < `CSR_NUM_WR; i++) begin
				// the new value lands on the same edge as the writeback
				if (wr_en[i]) begin
					csr_q[i] <= wdata;
				end
			end
		end
	end

	// the registers leave by name for the read mux
	assign mstatus = csr_q[0];
	assign mie = csr_q[1];
	assign mtvec = csr_q[2];
	assign mepc = csr_q[3];
	assign mcause = csr_q[4];
	assign mtval = csr_q[5];
	assign mip = csr_q[6];

endmodule

/* csr_pkg.sv */
/*
 * shared vector types of the CSR execute unit
 * data, address, renamed destination, one-hot select, write enables, function
 */
`include "csr_config.svh"

package csr_pkg;

	// one CSR value or one source operand of csrrw, csrrs or csrrc
	typedef logic [`CSR_XLEN-1:0] csr_data_t;

	// the 12-bit CSR address field of the instruction
	typedef logic [11:0] csr_addr_t;

	// renamed destination index, architectural 5 bits plus rename bits
	// index zero with rename bits zero means x0, so the read is suppressed on csrrw
	typedef logic [5+`CSR_RNBIT-1:0] csr_rd_t;

	// one-hot CSR select, one bit per decoded register
	// bit 0 mstatus, bit 1 mie, bit 2 mtvec, bit 3 mepc
	// bit 4 mcause, bit 5 mtval, bit 6 mip
	// bit 7 misa, bit 8 mvendorid, bit 9 marchid, bit 10 mimpid, bit 11 mhartid
	// the writable registers sit in the low bits so the write enables
	// are simply the low slice of the select
	// an all-zero select means the address is unknown
	typedef logic [`CSR_NUM-1:0] csr_sel_t;

	// per-register write enables in the same order as the low select bits
	// bit 0 mstatus up to bit 6 mip
	typedef logic [`CSR_NUM_WR-1:0] csr_wr_t;

	// one-hot function of the operation
	// bit 0 write (csrrw), bit 1 set (csrrs), bit 2 clear (csrrc)
	// the immediate forms share these strobes, only the operand source differs
	typedef logic [2:0] csr_fn_t;

endpackage

/* csr_read_mux.sv */
/*
 * one-hot read selection over the writable CSRs and the read-only
 * machine information constants
 */
`timescale 1ns/1ps
`include "csr_config.svh"

module csr_read_mux
	import csr_pkg::*;
(
	// one-hot, bit order as in csr_sel_t
	input csr_sel_t sel,

	input csr_data_t mstatus,
	input csr_data_t mie,
	input csr_data_t mtvec,
	input csr_data_t mepc,
	input csr_data_t mcause,
	input csr_data_t mtval,
	input csr_data_t mip,

	output csr_data_t rdata
);

	csr_data_t rdata_wr;
	csr_data_t rdata_ro;

	// writable registers, each masked by its own select bit
	assign rdata_wr = ({`CSR_XLEN{sel[0]}} & mstatus)
		| ({`CSR_XLEN{sel[1]}} & mie)
		| ({`CSR_XLEN{sel[2]}} & mtvec)
		| ({`CSR_XLEN{sel[3]}} & mepc)
		| ({`CSR_XLEN{sel[4]}} & mcause)
		| ({`CSR_XLEN{sel[5]}} & mtval)
		| ({`CSR_XLEN{sel[6]}} & mip);

	// read-only information registers
	// most of these are zero constants and trim away in synthesis
	// mvendorid is only 32 bits wide and reads zero-extended
	assign rdata_ro = ({`CSR_XLEN{sel[7]}} & `CSR_MISA_VAL)
		| ({`CSR_XLEN{sel[8]}} & {{(`CSR_XLEN-32){1'b0}}, `CSR_MVENDORID_VAL})
		| ({`CSR_XLEN{sel[9]}} & `CSR_MARCHID_VAL)
		| ({`CSR_XLEN{sel[10]}} & `CSR_MIMPID_VAL)
		| ({`CSR_XLEN{sel[11]}} & `CSR_HART_ID);

	// an empty select masks every term, so an unknown address reads zero
	assign rdata = rdata_wr | rdata_ro;

endmodule

/* tb_csr_exe_top.sv */
/*
 * testbench of the CSR execute unit
 * reference model with its own CSR array, directed and random stimulus,
 * a compare process one cycle after each operation and a cycle timeout
 */
`timescale 1ns/1ps
`include "csr_config.svh"

module tb_csr_exe_top
	import csr_pkg::*;
();

	// directed phases plus the random back-to-back phase
	localparam int N_RAND = 200;
	localparam int N_OPS = 7 + 29 + 56 + 14 + 8 + N_RAND;
	localparam int LIMIT = N_OPS + 50;

	logic CLK;
	logic arst_n;
	logic csr_valid;
	logic csr_rw;
	logic csr_rs;
	logic csr_rc;
	csr_rd_t csr_rd;
	csr_data_t csr_op;
	csr_addr_t csr_addr;
	logic wb_valid;
	csr_data_t wb_res;
	csr_rd_t wb_rd;

	// model copy of mstatus, mie, mtvec, mepc, mcause, mtval, mip
	csr_data_t ref_regs [7];
	// expected result of the operation in flight, never more than one
	csr_data_t exp_res [$];
	csr_rd_t exp_rd [$];
	logic [31:0] lcg_state;
	// results compared so far, one per issued operation
	int n_checked;
	int cycle_cnt;
	csr_addr_t wr_addr [7];
	csr_addr_t ro_addr [5];
	csr_addr_t unk_addr [4];
	csr_addr_t all_addr [16];

	csr_exe_top i_dut (
		.CLK(CLK),
		.arst_n(arst_n),
		.csr_valid(csr_valid),
		.csr_rw(csr_rw),
		.csr_rs(csr_rs),
		.csr_rc(csr_rc),
		.csr_rd(csr_rd),
		.csr_op(csr_op),
		.csr_addr(csr_addr),
		.wb_valid(wb_valid),
		.wb_res(wb_res),
		.wb_rd(wb_rd)
	);

	always #2 CLK = ~CLK;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic csr_data_t rand64();
		csr_data_t v;
		v[63:32] = lcg_next();
		v[31:0] = lcg_next();
		return v;
	endfunction

	// expected old value of one operation, updates the model registers
	function automatic csr_data_t ref_exec(input logic rw, input logic rs,
		input csr_rd_t rd, input csr_data_t opnd, input csr_addr_t addr);
		int idx;
		csr_data_t old;
		csr_data_t res;
		idx = -1;
		old = '0;
		case (addr)
			`CSR_ADDR_MSTATUS: idx = 0;
			`CSR_ADDR_MIE: idx = 1;
			`CSR_ADDR_MTVEC: idx = 2;
			`CSR_ADDR_MEPC: idx = 3;
			`CSR_ADDR_MCAUSE: idx = 4;
			`CSR_ADDR_MTVAL: idx = 5;
			`CSR_ADDR_MIP: idx = 6;
			`CSR_ADDR_MISA: old = `CSR_MISA_VAL;
			`CSR_ADDR_MVENDORID: old = {32'h0, `CSR_MVENDORID_VAL};
			`CSR_ADDR_MARCHID: old = `CSR_MARCHID_VAL;
			`CSR_ADDR_MIMPID: old = `CSR_MIMPID_VAL;
			`CSR_ADDR_MHARTID: old = `CSR_HART_ID;
			default: old = '0;
		endcase
		if (idx >= 0) begin
			old = ref_regs[idx];
		end
		// csrrw into x0 reads nothing and returns zero
		res = (rw && rd == '0) ? '0 : old;
		// set and clear with a zero operand leave the register alone
		if (idx >= 0 && (rw || opnd != '0)) begin
			if (rw) begin
				ref_regs[idx] = opnd;
			end else if (rs) begin
				ref_regs[idx] = old | opnd;
			end else begin
				ref_regs[idx] = old & ~opnd;
			end
		end
		return res;
	endfunction

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED time=%0t %s got=%h expected=%h", $time, name, got, exp);
			$display("Simulation failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// one operation on the next falling edge, with its expected result queued
	task automatic issue_op(input logic rw, input logic rs, input logic rc,
		input csr_rd_t rd, input csr_data_t opnd, input csr_addr_t addr);
		@(negedge CLK);
		csr_valid = 1'b1;
		csr_rw = rw;
		csr_rs = rs;
		csr_rc = rc;
		csr_rd = rd;
		csr_op = opnd;
		csr_addr = addr;
		exp_res.push_back(ref_exec(rw, rs, rd, opnd, addr));
		exp_rd.push_back(rd);
	endtask

	task automatic go_idle();
		@(negedge CLK);
		csr_valid = 1'b0;
		csr_rw = 1'b0;
		csr_rs = 1'b0;
		csr_rc = 1'b0;
	endtask

	// outputs settle just after the rising edge, so they are sampled 1 ns later
	// a cycle with nothing queued must show wb_valid low
	always @(posedge CLK) begin
		#1;
		if (arst_n) begin
			if (exp_res.size() != 0) begin
				check("wb_valid", wb_valid, 64'd1);
				check("wb_res", wb_res, exp_res.pop_front());
				check("wb_rd", {57'd0, wb_rd}, {57'd0, exp_rd.pop_front()});
				n_checked++;
			end else begin
				check("wb_valid", wb_valid, 64'd0);
			end
		end
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < LIMIT) begin
			@(posedge CLK);
			cycle_cnt++;
		end
		$display("timeout after %0d cycles, the run did not finish", LIMIT);
		$display("Simulation failed");
		$fatal(1, "timeout");
	end

	initial begin
		logic [31:0] r;
		csr_data_t v;
		CLK = 1'b0;
		arst_n = 1'b0;
		csr_valid = 1'b0;
		csr_rw = 1'b0;
		csr_rs = 1'b0;
		csr_rc = 1'b0;
		csr_rd = '0;
		csr_op = '0;
		csr_addr = '0;
		n_checked = 0;
		lcg_state = 32'hf3d3;
		for (int i = 0; i < 7; i++) begin
			ref_regs[i] = '0;
		end
		wr_addr = '{`CSR_ADDR_MSTATUS, `CSR_ADDR_MIE, `CSR_ADDR_MTVEC, `CSR_ADDR_MEPC,
			`CSR_ADDR_MCAUSE, `CSR_ADDR_MTVAL, `CSR_ADDR_MIP};
		ro_addr = '{`CSR_ADDR_MISA, `CSR_ADDR_MHARTID, `CSR_ADDR_MVENDORID,
			`CSR_ADDR_MARCHID, `CSR_ADDR_MIMPID};
		// mcounteren and mcycle are not decoded here, so they count as unknown
		unk_addr = '{12'h7c0, 12'h000, 12'h306, 12'hb00};
		for (int i = 0; i < 7; i++) begin
			all_addr[i] = wr_addr[i];
		end
		for (int i = 0; i < 5; i++) begin
			all_addr[7 + i] = ro_addr[i];
		end
		for (int i = 0; i < 4; i++) begin
			all_addr[12 + i] = unk_addr[i];
		end

		repeat (2) @(posedge CLK);
		@(negedge CLK);
		arst_n = 1'b1;

		// reset values read back through csrrs with a zero operand
		for (int i = 0; i < 7; i++) begin
			issue_op(0, 1, 0, 7'(i + 1), '0, wr_addr[i]);
		end
		// full writes then reads, and the read-only registers ignore writes
		for (int i = 0; i < 7; i++) begin
			issue_op(1, 0, 0, 7'(16 + i), rand64(), wr_addr[i]);
		end
		for (int i = 0; i < 7; i++) begin
			issue_op(0, 1, 0, 7'(32 + i), '0, wr_addr[i]);
		end
		for (int i = 0; i < 5; i++) begin
			issue_op(0, 1, 0, 7'(40 + i), '0, ro_addr[i]);
		end
		for (int i = 0; i < 5; i++) begin
			issue_op(1, 0, 0, 7'(48 + i), rand64(), ro_addr[i]);
			issue_op(0, 1, 0, 7'(56 + i), '0, ro_addr[i]);
		end
		// set and clear merges, zero operands must not disturb the value
		for (int i = 0; i < 7; i++) begin
			issue_op(0, 1, 0, 7'd3, rand64(), wr_addr[i]);
			issue_op(0, 1, 0, 7'd4, '0, wr_addr[i]);
			issue_op(0, 0, 1, 7'd5, rand64(), wr_addr[i]);
			issue_op(0, 1, 0, 7'd6, '0, wr_addr[i]);
			issue_op(0, 0, 1, 7'd7, '0, wr_addr[i]);
			issue_op(0, 1, 0, 7'd8, '0, wr_addr[i]);
			issue_op(1, 0, 0, 7'd9, rand64(), wr_addr[i]);
			issue_op(0, 0, 1, 7'd10, '0, wr_addr[i]);
		end
		// csrrw into x0 still writes, unknown addresses neither read nor write
		for (int i = 0; i < 7; i++) begin
			issue_op(1, 0, 0, '0, rand64(), wr_addr[i]);
			issue_op(0, 1, 0, 7'd11, '0, wr_addr[i]);
		end
		for (int i = 0; i < 4; i++) begin
			issue_op(1, 0, 0, 7'd12, rand64(), unk_addr[i]);
			issue_op(0, 1, 0, 7'd13, '0, unk_addr[i]);
		end
		// random back-to-back traffic, x0 and zero operands now and then
		for (int n = 0; n < N_RAND; n++) begin
			r = lcg_next();
			v = (r[13:11] == 3'd0) ? '0 : rand64();
			issue_op(r[1:0] == 2'd0, r[1:0] == 2'd1, r[1:0] >= 2'd2,
				(r[10:8] == 3'd0) ? '0 : r[22:16], v, all_addr[r[27:24]]);
		end
		go_idle();
		@(posedge CLK);
		#2;
		if (n_checked == N_OPS && exp_res.size() == 0) begin
			$display("Simulation passed");
		end else begin
			$display("only %0d of %0d operations were compared", n_checked, N_OPS);
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
